/* Makefile */
VERILATOR ?= verilator
TOP       := tb_conv_layer
FILELIST  := conv_layer.f
VFLAGS    := --binary --timing --assert -j 0 -Wno-fatal
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* conv_layer.f */
rtl/cnn_pkg.sv
rtl/mem_bus_if.sv
rtl/mem_arbiter.sv
rtl/tile_loader.sv
rtl/conv_sequencer.sv
rtl/conv_pe.sv
rtl/max_pool.sv
rtl/result_writer.sv
rtl/conv_layer.sv
tests/tb_conv_layer.sv

/* rtl/cnn_pkg.sv */
`default_nettype none

package cnn_pkg;

  // layer geometry
  localparam int IMG_DIM   = 6;
  localparam int K_DIM     = 3;
  localparam int OUT_DIM   = 4;  // IMG_DIM - K_DIM + 1
  localparam int POOL_DIM  = 2;
  localparam int N_CH      = 4;  // filters, one PE each

  // memory layout, four bytes per word, first byte on top
  localparam int IMG_WORDS = 9;
  localparam int W_WORDS   = 9;
  localparam int OUT_WORDS = 4;  // one word per channel
  localparam int ADDR_W    = 8;

  typedef logic [7:0]         byte_t;
  typedef logic signed [7:0]  wgt_t;
  typedef logic [31:0]        word_t;
  typedef logic signed [31:0] acc_t;

  typedef byte_t [K_DIM*K_DIM-1:0]     window_t;     // index ky*K_DIM + kx
  typedef wgt_t  [K_DIM*K_DIM-1:0]     kernel_t;
  typedef byte_t [IMG_DIM*IMG_DIM-1:0] img_cache_t;  // row-major pixels

  // [channel][pooled position]
  typedef byte_t [N_CH-1:0][POOL_DIM*POOL_DIM-1:0] pool_out_t;

endpackage

`default_nettype wire

/* rtl/conv_layer.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_layer import cnn_pkg::*; #(
  parameter int IMG_BASE    = 0,
  parameter int W_BASE      = 16,
  parameter int OUT_BASE    = 32,
  parameter int QUANT_SHIFT = 4
) (
  input  wire               clk,
  input  wire               rst,
  input  wire               i_start,
  output logic              o_busy,
  output logic              o_done,
  output logic              o_mem_en,
  output logic              o_mem_we,
  output logic [ADDR_W-1:0] o_mem_addr,
  output word_t             o_mem_wdata,
  input  wire word_t        i_mem_rdata
);

  mem_bus_if load_bus ();
  mem_bus_if write_bus ();

  logic             load, loaded, flush, written;
  img_cache_t       img;
  kernel_t          kernels [N_CH];
  window_t          window;
  logic             win_valid;
  byte_t [N_CH-1:0] pe_result;
  logic [N_CH-1:0]  pe_valid;
  pool_out_t        pooled;

  mem_arbiter u_arb (
    .clk, .rst, .m_load(load_bus.slave), .m_write(write_bus.slave),
    .o_mem_en, .o_mem_we, .o_mem_addr, .o_mem_wdata, .i_mem_rdata
  );

  tile_loader #(.IMG_BASE(IMG_BASE), .W_BASE(W_BASE)) u_loader (
    .clk, .rst, .i_load(load), .o_loaded(loaded), .bus(load_bus.master),
    .o_img(img), .o_kernels(kernels)
  );

  conv_sequencer u_seq (
    .clk, .rst, .i_start, .o_busy, .o_done,
    .o_load(load), .i_loaded(loaded), .o_flush(flush), .i_written(written),
    .i_img(img), .o_window(window), .o_win_valid(win_valid)
  );

  // same window to every PE, one filter each
  for (genvar c = 0; c < N_CH; c++) begin : g_pe
    conv_pe #(.QUANT_SHIFT(QUANT_SHIFT)) u_pe (
      .clk, .rst, .i_window(window), .i_kernel(kernels[c]), .i_valid(win_valid),
      .o_result(pe_result[c]), .o_valid(pe_valid[c])
    );
  end

  max_pool u_pool (
    .clk, .rst, .i_results(pe_result), .i_valid(&pe_valid), .o_pooled(pooled)
  );

  result_writer #(.OUT_BASE(OUT_BASE)) u_writer (
    .clk, .rst, .i_flush(flush), .o_written(written), .i_pooled(pooled),
    .bus(write_bus.master)
  );

endmodule

`default_nettype wire

/* rtl/conv_pe.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_pe import cnn_pkg::*; #(
  parameter int QUANT_SHIFT = 4
) (
  input  wire          clk,
  input  wire          rst,
  input  wire window_t i_window,
  input  wire kernel_t i_kernel,
  input  wire          i_valid,
  output byte_t        o_result,
  output logic         o_valid
);

  acc_t  sum;
  acc_t  shifted;
  byte_t quant;

  always_comb begin
    sum = '0;
    for (int k = 0; k < K_DIM*K_DIM; k++) begin
      sum = sum + $signed({1'b0, i_window[k]}) * $signed(i_kernel[k]);  // pixel is unsigned
    end
    shifted = sum >>> QUANT_SHIFT;
    if (sum < 0)
      quant = 8'd0;                  // relu
    else if (shifted > 255)
      quant = 8'd255;                // saturate
    else
      quant = shifted[7:0];
  end

  always_ff @(posedge clk) begin
    if (i_valid) o_result <= quant;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) o_valid <= 1'b0;
    else     o_valid <= i_valid;
  end

endmodule

`default_nettype wire

/* rtl/conv_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_sequencer import cnn_pkg::*; (
  input  wire             clk,
  input  wire             rst,
  input  wire             i_start,
  output logic            o_busy,
  output logic            o_done,
  output logic            o_load,
  input  wire             i_loaded,
  output logic            o_flush,
  input  wire             i_written,
  input  wire img_cache_t i_img,
  output window_t         o_window,
  output logic            o_win_valid
);

  localparam int N_POS = OUT_DIM * OUT_DIM;

  typedef enum logic [2:0] {
    ST_IDLE, ST_LOAD, ST_CONV, ST_DRAIN, ST_WRITE, ST_DONE
  } state_t;

  state_t     state;
  logic [3:0] pos;       // position of the window now on o_window
  logic [3:0] nxt_pos;
  logic [1:0] row, col;
  window_t    nxt_win;
  logic       win_load;

  // pos bits {by, bx, sy, sx}, so the four members of a pool block are adjacent
  always_comb begin
    nxt_pos = (state == ST_LOAD) ? 4'd0 : pos + 1'b1;
    row     = {nxt_pos[3], nxt_pos[1]};
    col     = {nxt_pos[2], nxt_pos[0]};
    for (int ky = 0; ky < K_DIM; ky++) begin
      for (int kx = 0; kx < K_DIM; kx++) begin
        nxt_win[ky*K_DIM + kx] = i_img[(row + ky)*IMG_DIM + col + kx];
      end
    end
  end

  assign win_load = (state == ST_LOAD && i_loaded) ||
                    (state == ST_CONV && pos != N_POS - 1);

  always_ff @(posedge clk) begin
    if (win_load) o_window <= nxt_win;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state       <= ST_IDLE;
      pos         <= '0;
      o_win_valid <= 1'b0;
      o_load      <= 1'b0;
      o_flush     <= 1'b0;
    end else begin
      o_load  <= (state == ST_IDLE) && i_start;
      o_flush <= (state == ST_DRAIN);
      case (state)
        ST_IDLE:  if (i_start) state <= ST_LOAD;
        ST_LOAD: begin
          if (i_loaded) begin
            state       <= ST_CONV;
            pos         <= '0;
            o_win_valid <= 1'b1;
          end
        end
        ST_CONV: begin
          if (pos == N_POS - 1) begin
            state       <= ST_DRAIN;
            o_win_valid <= 1'b0;
          end else begin
            pos <= pos + 1'b1;
          end
        end
        ST_DRAIN: state <= ST_WRITE;  // lets the PE register empty
        ST_WRITE: if (i_written) state <= ST_DONE;
        ST_DONE:  state <= ST_IDLE;
        default:  state <= ST_IDLE;
      endcase
    end
  end

  assign o_busy = (state == ST_LOAD) || (state == ST_CONV) ||
                  (state == ST_DRAIN) || (state == ST_WRITE);
  assign o_done = (state == ST_DONE);

  a_valid_conv: assert property (@(posedge clk) disable iff (rst)
    o_win_valid |-> state == ST_CONV);

  // one unbroken burst of windows per layer
  a_burst: assert property (@(posedge clk) disable iff (rst)
    $rose(o_win_valid) |-> o_win_valid [*N_POS] ##1 !o_win_valid);

endmodule

`default_nettype wire

/* rtl/max_pool.sv */
`timescale 1ns/1ps
`default_nettype none

module max_pool import cnn_pkg::*; (
  input  wire                     clk,
  input  wire                     rst,
  input  wire byte_t [N_CH-1:0]   i_results,
  input  wire                     i_valid,
  output pool_out_t               o_pooled
);

  logic [1:0]       cnt;  // member within the 2x2 block
  logic [1:0]       blk;  // pooled position being built
  byte_t [N_CH-1:0] run_max;
  byte_t [N_CH-1:0] blk_max;

  always_comb begin
    for (int c = 0; c < N_CH; c++) begin
      if (cnt == 2'd0 || i_results[c] > run_max[c])
        blk_max[c] = i_results[c];
      else
        blk_max[c] = run_max[c];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt <= '0;
      blk <= '0;
    end else if (i_valid) begin
      cnt <= cnt + 1'b1;
      if (cnt == 2'd3) blk <= blk + 1'b1;  // wraps after the last block
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid) begin
      run_max <= blk_max;
      if (cnt == 2'd3) begin
        for (int c = 0; c < N_CH; c++) begin
          o_pooled[c][blk] <= blk_max[c];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import cnn_pkg::*; (
  input  wire               clk,
  input  wire               rst,
  mem_bus_if.slave          m_load,
  mem_bus_if.slave          m_write,
  output logic              o_mem_en,
  output logic              o_mem_we,
  output logic [ADDR_W-1:0] o_mem_addr,
  output word_t             o_mem_wdata,
  input  wire word_t        i_mem_rdata
);

  logic rd_load_q, rd_write_q;  // who owns the data coming back

  // writer wins
  assign m_write.gnt = m_write.req;
  assign m_load.gnt  = m_load.req & ~m_write.req;

  assign o_mem_en    = m_load.req | m_write.req;
  assign o_mem_we    = m_write.gnt ? m_write.we    : m_load.we;
  assign o_mem_addr  = m_write.gnt ? m_write.addr  : m_load.addr;
  assign o_mem_wdata = m_write.gnt ? m_write.wdata : m_load.wdata;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_load_q  <= 1'b0;
      rd_write_q <= 1'b0;
    end else begin
      rd_load_q  <= m_load.gnt & ~m_load.we;
      rd_write_q <= m_write.gnt & ~m_write.we;
    end
  end

  assign m_load.rvalid  = rd_load_q;
  assign m_load.rdata   = rd_load_q ? i_mem_rdata : '0;
  assign m_write.rvalid = rd_write_q;
  assign m_write.rdata  = rd_write_q ? i_mem_rdata : '0;

  // loader and writer phases of the layer never overlap, so grants never collide
  a_no_overlap: assert property (@(posedge clk) disable iff (rst)
    !(m_load.req && m_write.req));

  // only the loader reads, so rvalid never reaches the writer
  a_write_only: assert property (@(posedge clk) disable iff (rst)
    m_write.req |-> m_write.we);

endmodule

`default_nettype wire

/* rtl/mem_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one requester on the shared memory port
interface mem_bus_if import cnn_pkg::*; ();

  logic              req;
  logic              we;
  logic [ADDR_W-1:0] addr;
  word_t             wdata;
  logic              gnt;     // transfer when req && gnt
  logic              rvalid;  // one cycle after a granted read
  word_t             rdata;

  modport master (output req, we, addr, wdata, input gnt, rvalid, rdata);
  modport slave  (input req, we, addr, wdata, output gnt, rvalid, rdata);

endinterface

`default_nettype wire

/* rtl/result_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module result_writer import cnn_pkg::*; #(
  parameter int OUT_BASE = 32
) (
  input  wire            clk,
  input  wire            rst,
  input  wire            i_flush,
  output logic           o_written,
  input  wire pool_out_t i_pooled,
  mem_bus_if.master      bus
);

  localparam int IDX_W = $clog2(OUT_WORDS);

  logic             busy_q;
  logic [IDX_W-1:0] w_idx;  // channel being written

  assign bus.req  = busy_q;
  assign bus.we   = 1'b1;
  assign bus.addr = ADDR_W'(OUT_BASE + w_idx);

  // pooled position 0 in the top byte
  always_comb begin
    for (int p = 0; p < POOL_DIM*POOL_DIM; p++) begin
      bus.wdata[31-8*p -: 8] = i_pooled[w_idx][p];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy_q    <= 1'b0;
      w_idx     <= '0;
      o_written <= 1'b0;
    end else begin
      o_written <= bus.gnt && (w_idx == OUT_WORDS - 1);
      if (i_flush) begin
        busy_q <= 1'b1;
        w_idx  <= '0;
      end else if (bus.gnt) begin
        w_idx <= w_idx + 1'b1;
        if (w_idx == OUT_WORDS - 1) busy_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/tile_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module tile_loader import cnn_pkg::*; #(
  parameter int IMG_BASE = 0,
  parameter int W_BASE   = 16
) (
  input  wire        clk,
  input  wire        rst,
  input  wire        i_load,
  output logic       o_loaded,
  mem_bus_if.master  bus,
  output img_cache_t o_img,
  output kernel_t    o_kernels [N_CH]
);

  localparam int N_WORDS = IMG_WORDS + W_WORDS;

  logic       req_on;
  logic [4:0] req_cnt;  // next word to request
  logic [4:0] rx_cnt;   // next word to arrive

  img_cache_t                       img_q;
  byte_t [N_CH*K_DIM*K_DIM-1:0]     wgt_q;  // filters back to back

  // read only
  assign bus.req   = req_on;
  assign bus.we    = 1'b0;
  assign bus.wdata = '0;
  assign bus.addr  = (req_cnt < IMG_WORDS) ? ADDR_W'(IMG_BASE + req_cnt)
                                           : ADDR_W'(W_BASE + req_cnt - IMG_WORDS);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      req_on   <= 1'b0;
      req_cnt  <= '0;
      rx_cnt   <= '0;
      o_loaded <= 1'b0;
    end else begin
      o_loaded <= bus.rvalid && (rx_cnt == N_WORDS - 1);
      if (i_load) begin
        req_on  <= 1'b1;
        req_cnt <= '0;
        rx_cnt  <= '0;
      end else begin
        if (bus.gnt) begin
          req_cnt <= req_cnt + 1'b1;
          if (req_cnt == N_WORDS - 1) req_on <= 1'b0;  // last request taken
        end
        if (bus.rvalid) rx_cnt <= rx_cnt + 1'b1;
      end
    end
  end

  // unpack, first byte in the top bits
  always_ff @(posedge clk) begin
    if (bus.rvalid) begin
      for (int b = 0; b < 4; b++) begin
        if (rx_cnt < IMG_WORDS)
          img_q[rx_cnt*4 + b] <= bus.rdata[31-8*b -: 8];
        else
          wgt_q[(rx_cnt-IMG_WORDS)*4 + b] <= bus.rdata[31-8*b -: 8];
      end
    end
  end

  assign o_img = img_q;

  always_comb begin
    for (int c = 0; c < N_CH; c++) begin
      for (int k = 0; k < K_DIM*K_DIM; k++) begin
        o_kernels[c][k] = wgt_t'(wgt_q[c*K_DIM*K_DIM + k]);
      end
    end
  end

endmodule

`default_nettype wire

/* tests/tb_conv_layer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_conv_layer import cnn_pkg::*; ();

  localparam int IMG_BASE    = 0;
  localparam int W_BASE      = 16;
  localparam int OUT_BASE    = 32;
  localparam int QUANT_SHIFT = 4;
  localparam int MEM_WORDS   = 64;
  localparam int RUN_LIMIT   = 500;  // cycles per layer

  // kinds of layer data
  localparam int LAYER_RANDOM   = 0;
  localparam int LAYER_NEG_WGT  = 1;  // all weights -1
  localparam int LAYER_SATURATE = 2;  // pixels 255, weights 127

  logic              clk;
  logic              rst;
  logic              i_start;
  logic              o_busy;
  logic              o_done;
  logic              o_mem_en;
  logic              o_mem_we;
  logic [ADDR_W-1:0] o_mem_addr;
  word_t             o_mem_wdata;
  word_t             i_mem_rdata;

  word_t       mem    [MEM_WORDS];
  word_t       shadow [MEM_WORDS];  // memory as loaded before the run
  logic [31:0] lfsr_state;
  int          done_count;
  logic        done_q;

  conv_layer UUT (
    .clk, .rst, .i_start, .o_busy, .o_done,
    .o_mem_en, .o_mem_we, .o_mem_addr, .o_mem_wdata, .i_mem_rdata
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("FAIL t=%0t %s got=%h expected=%h", $time, name, got, exp));
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic bit in_input_region(input int a);
    return (a >= IMG_BASE && a < IMG_BASE + IMG_WORDS) ||
           (a >= W_BASE && a < W_BASE + W_WORDS);
  endfunction

  // byte idx of a packed region, first byte in the top bits
  function automatic int byte_at(input int base, input int idx);
    return int'((mem[base + idx / 4] >> (24 - 8 * (idx % 4))) & 32'hFF);
  endfunction

  function automatic int conv_out(input int ch, input int r, input int c);
    int sum;
    int w;
    sum = 0;
    for (int ky = 0; ky < 3; ky++) begin
      for (int kx = 0; kx < 3; kx++) begin
        w = byte_at(W_BASE, ch * 9 + ky * 3 + kx);
        if (w > 127) w = w - 256;  // signed weight
        sum = sum + byte_at(IMG_BASE, (r + ky) * 6 + c + kx) * w;
      end
    end
    if (sum < 0) return 0;
    sum = sum >> QUANT_SHIFT;
    return (sum > 255) ? 255 : sum;
  endfunction

  function automatic word_t expected_word(input int ch);
    word_t w;
    int    best;
    int    v;
    w = '0;
    for (int p = 0; p < 4; p++) begin
      best = 0;
      for (int s = 0; s < 4; s++) begin
        v = conv_out(ch, 2 * (p / 2) + s / 2, 2 * (p % 2) + s % 2);
        if (v > best) best = v;
      end
      w[31 - 8 * p -: 8] = 8'(best);
    end
    return w;
  endfunction

  // request taken mid-cycle, served at the edge
  always begin : memory_model
    logic        en;
    logic        we;
    logic [5:0]  addr;
    word_t       wdata;
    word_t       rd;
    @(negedge clk);
    en    = o_mem_en;
    we    = o_mem_we;
    addr  = o_mem_addr[5:0];
    wdata = o_mem_wdata;
    @(posedge clk);
    if (en && we) mem[addr] = wdata;
    rd = mem[addr];
    #1;
    if (en && !we) i_mem_rdata = rd;
  end

  always @(negedge clk) begin : bus_monitor
    if (rst) begin
      done_q = 1'b0;
    end else begin
      if (o_mem_en && o_mem_we &&
          (o_mem_addr < OUT_BASE || o_mem_addr >= OUT_BASE + OUT_WORDS))
        abort_run($sformatf("write to address %0d outside the output words", o_mem_addr));
      if (o_mem_en && !o_mem_we && !in_input_region(int'(o_mem_addr)))
        abort_run($sformatf("read from address %0d outside image and weights", o_mem_addr));
      if (o_done && done_q) abort_run("o_done stayed high for more than one cycle");
      if (o_done && o_busy) abort_run("o_busy still high while o_done is high");
      if (o_done) done_count++;
      done_q = o_done;
    end
  end

  always @(negedge clk) begin : compare_outputs
    if (!rst && o_done) begin
      for (int c = 0; c < OUT_WORDS; c++)
        check_equal($sformatf("mem[%0d]", OUT_BASE + c), mem[OUT_BASE + c], expected_word(c));
      for (int a = 0; a < MEM_WORDS; a++) begin
        if (in_input_region(a))
          check_equal($sformatf("input mem[%0d]", a), mem[a], shadow[a]);
      end
    end
  end

  task automatic check_quiet_outputs();
    check_equal("o_mem_en", o_mem_en, 0);
    check_equal("o_mem_we", o_mem_we, 0);
    check_equal("o_busy", o_busy, 0);
    check_equal("o_done", o_done, 0);
  endtask

  task automatic load_layer(input int kind);
    logic [3:0] nib;
    @(posedge clk);
    #1;
    for (int a = 0; a < IMG_WORDS; a++)
      mem[IMG_BASE + a] = (kind == LAYER_SATURATE) ? 32'hFFFF_FFFF : random_bits(32);
    for (int a = 0; a < W_WORDS; a++) begin
      for (int b = 0; b < 4; b++) begin
        if (kind == LAYER_RANDOM) begin
          nib = 4'(random_bits(4));  // small weights keep sums mid-range
          mem[W_BASE + a][31 - 8 * b -: 8] = {{4{nib[3]}}, nib};
        end else begin
          mem[W_BASE + a][31 - 8 * b -: 8] = (kind == LAYER_NEG_WGT) ? 8'hFF : 8'h7F;
        end
      end
    end
    for (int c = 0; c < OUT_WORDS; c++)
      mem[OUT_BASE + c] = random_bits(32);  // stale results
    for (int a = 0; a < MEM_WORDS; a++)
      shadow[a] = mem[a];
  endtask

  task automatic pulse_start();
    @(posedge clk);
    #1 i_start = 1'b1;
    @(posedge clk);
    #1 i_start = 1'b0;
  endtask

  task automatic wait_busy(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (!o_busy) begin
      if (n == limit) abort_run("timeout waiting for o_busy");
      n++;
      @(negedge clk);
    end
  endtask

  task automatic wait_done(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (!o_done) begin
      if (n == limit) abort_run("timeout waiting for o_done");
      n++;
      @(negedge clk);
    end
  endtask

  task automatic run_layer();
    pulse_start();
    @(negedge clk);
    check_equal("o_busy", o_busy, 1);  // cycle after the start was taken
    wait_done(RUN_LIMIT);
  endtask

  initial begin : stimulus
    int done_before;
    rst         = 1'b1;
    i_start     = 1'b0;
    i_mem_rdata = '0;
    done_count  = 0;
    lfsr_state  = 32'h45249d19;
    for (int a = 0; a < MEM_WORDS; a++)
      mem[a] = {8'h5A, 8'(a), 8'(~a), 8'(a)};

    repeat (16) begin
      @(negedge clk);
      check_quiet_outputs();
    end
    @(posedge clk);
    #1 rst = 1'b0;
    @(negedge clk);
    check_quiet_outputs();  // first cycle out of reset

    repeat (3) begin
      load_layer(LAYER_RANDOM);
      run_layer();
    end

    load_layer(LAYER_NEG_WGT);
    run_layer();
    for (int c = 0; c < OUT_WORDS; c++)
      check_equal($sformatf("relu mem[%0d]", OUT_BASE + c), mem[OUT_BASE + c], 32'h0);

    load_layer(LAYER_SATURATE);
    run_layer();
    for (int c = 0; c < OUT_WORDS; c++)
      check_equal($sformatf("sat mem[%0d]", OUT_BASE + c), mem[OUT_BASE + c], 32'hFFFF_FFFF);

    // second start while busy must be dropped
    load_layer(LAYER_RANDOM);
    done_before = done_count;
    pulse_start();
    wait_busy(10);
    pulse_start();
    wait_done(RUN_LIMIT);
    repeat (RUN_LIMIT) @(negedge clk);  // longer than a whole layer
    check_equal("o_done pulses", done_count - done_before, 1);

    load_layer(LAYER_RANDOM);
    run_layer();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
